// ==== verilog/idPkg.sv ====
// instruction word union, ALU and extension enums, opcode and funct codes, bubble word
package idPkg;

    // R-type view for register to register ALU ops
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rTypeT;

    // I-type view that also carries the J-type index as {rs, rt, imm}
    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iTypeT;

    typedef union packed {
        rTypeT rType;
        iTypeT iType;
    } instrWordT;

    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluSlt = 3'd4,
        aluLui = 3'd5
    } aluOpT;

    typedef enum logic [1:0] {
        extZero  = 2'd0,
        extSign  = 2'd1,
        extUpper = 2'd2
    } extOpT;

    // bubble held by IF/ID after flush or reset
    localparam logic [31:0] nopInstr = 32'h0000_0000;

    // primary opcodes
    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opJ       = 6'h02;
    localparam logic [5:0] opJal     = 6'h03;
    localparam logic [5:0] opBeq     = 6'h04;
    localparam logic [5:0] opAddiu   = 6'h09;
    localparam logic [5:0] opSlti    = 6'h0a;
    localparam logic [5:0] opAndi    = 6'h0c;
    localparam logic [5:0] opOri     = 6'h0d;
    localparam logic [5:0] opLui     = 6'h0f;
    localparam logic [5:0] opLw      = 6'h23;
    localparam logic [5:0] opSw      = 6'h2b;

    // funct codes under opSpecial
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnSlt  = 6'h2a;

endpackage

// ==== verilog/ifIdReg.sv ====
// IF/ID pipeline register with hold, flush to bubble and reset PC
`timescale 1ns/1ps

module ifIdReg #(
    parameter logic [31:0] resetPc = 32'h0000_0000
) (
    input  logic             clk,
    input  logic             arstN,
    input  logic             idWr,
    input  logic             idFlush,
    input  logic             ifValid,
    input  logic [31:0]      ifInstr,
    input  logic [31:0]      ifPc,
    output logic             idValid,
    output idPkg::instrWordT idInstr,
    output logic [31:0]      idPc
);
    import idPkg::*;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            idValid <= 1'b0;
            idInstr <= nopInstr;
            idPc    <= resetPc;
        end else if (idFlush) begin
            // bubble keeps the PC
            idValid <= 1'b0;
            idInstr <= nopInstr;
        end else if (idWr) begin
            idValid <= ifValid;
            idInstr <= ifInstr;
            idPc    <= ifPc;
        end
        // otherwise hold for back-pressure or a stall
    end

endmodule

// ==== verilog/regFile.sv ====
// 32x32 register file, two combinational reads with writeback bypass, one write port
`timescale 1ns/1ps

module regFile (
    input  logic        clk,
    input  logic        arstN,
    input  logic        wbWrEn,
    input  logic [4:0]  wbDst,
    input  logic [31:0] wbResult,
    input  logic [4:0]  rs,
    input  logic [4:0]  rt,
    output logic [31:0] busA,
    output logic [31:0] busB
);
    logic [31:0] regs [32];

    // entry 0 is cleared on reset and never written
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wbWrEn && (wbDst != 5'd0)) begin
            regs[wbDst] <= wbResult;
        end
    end

    // same-cycle writeback wins over stored value
    function automatic logic [31:0] readPort(input logic [4:0] idx, input logic [31:0] stored);
        if (idx == 5'd0) begin
            return '0;
        end
        if (wbWrEn && (wbDst == idx)) begin
            return wbResult;
        end
        return stored;
    endfunction

    always_comb begin
        busA = readPort(rs, regs[rs]);
        busB = readPort(rt, regs[rt]);
    end

endmodule

// ==== verilog/instrDecoder.sv ====
// control decoder for the supported subset with immediate extension and destination select
`timescale 1ns/1ps

module instrDecoder (
    input  idPkg::instrWordT idInstr,
    input  logic             idValid,
    input  logic [31:0]      idPc,
    output logic [4:0]       rs,
    output logic [4:0]       rt,
    output logic [4:0]       dst,
    output logic [31:0]      imm32,
    output logic [31:0]      jumpTarget,
    output idPkg::aluOpT     aluOp,
    output logic             aluSrcImm,
    output logic             regWr,
    output logic             readMem,
    output logic             writeMem,
    output logic             isBranch,
    output logic             isImmJump,
    output logic             rsRead,
    output logic             rtRead,
    output logic             reservedInstr
);
    import idPkg::*;

    extOpT       extOp;
    logic [15:0] imm16;
    logic        rawRegWr;
    logic        rawReadMem;
    logic        rawWriteMem;
    logic        rawBranch;
    logic        rawImmJump;
    logic        rawReserved;

    assign rs    = idInstr.iType.rs;
    assign rt    = idInstr.rType.rt;
    assign imm16 = idInstr.iType.imm;

    // 26-bit index spans rs, rt and imm of the I-type view
    assign jumpTarget = {idPc[31:28], idInstr.iType.rs, idInstr.iType.rt, idInstr.iType.imm, 2'b00};

    always_comb begin
        aluOp       = aluAdd;
        aluSrcImm   = 1'b0;
        extOp       = extSign;
        dst         = 5'd0;
        rsRead      = 1'b0;
        rtRead      = 1'b0;
        rawRegWr    = 1'b0;
        rawReadMem  = 1'b0;
        rawWriteMem = 1'b0;
        rawBranch   = 1'b0;
        rawImmJump  = 1'b0;
        rawReserved = 1'b0;
        case (idInstr.rType.opcode)
            opSpecial: begin
                dst      = idInstr.rType.rd;
                rsRead   = 1'b1;
                rtRead   = 1'b1;
                rawRegWr = 1'b1;
                case (idInstr.rType.funct)
                    fnAddu:  aluOp = aluAdd;
                    fnSubu:  aluOp = aluSub;
                    fnAnd:   aluOp = aluAnd;
                    fnOr:    aluOp = aluOr;
                    fnSlt:   aluOp = aluSlt;
                    default: begin
                        rawRegWr    = 1'b0;
                        rawReserved = 1'b1;
                    end
                endcase
            end
            opAddiu, opSlti, opAndi, opOri, opLui: begin
                aluSrcImm = 1'b1;
                dst       = idInstr.iType.rt;
                rsRead    = (idInstr.iType.opcode != opLui);
                rawRegWr  = 1'b1;
                case (idInstr.iType.opcode)
                    opSlti:  aluOp = aluSlt;
                    opAndi:  aluOp = aluAnd;
                    opOri:   aluOp = aluOr;
                    opLui:   aluOp = aluLui;
                    default: aluOp = aluAdd;
                endcase
                if (idInstr.iType.opcode == opAndi || idInstr.iType.opcode == opOri) begin
                    extOp = extZero;
                end else if (idInstr.iType.opcode == opLui) begin
                    extOp = extUpper;
                end
            end
            opLw: begin
                aluSrcImm  = 1'b1;
                dst        = idInstr.iType.rt;
                rsRead     = 1'b1;
                rawRegWr   = 1'b1;
                rawReadMem = 1'b1;
            end
            opSw: begin
                aluSrcImm   = 1'b1;
                rsRead      = 1'b1;
                rtRead      = 1'b1;
                rawWriteMem = 1'b1;
            end
            opBeq: begin
                aluOp     = aluSub;
                rsRead    = 1'b1;
                rtRead    = 1'b1;
                rawBranch = 1'b1;
            end
            opJ: begin
                rawImmJump = 1'b1;
            end
            opJal: begin
                dst        = 5'd31;
                rawRegWr   = 1'b1;
                rawImmJump = 1'b1;
            end
            default: rawReserved = 1'b1;
        endcase
    end

    always_comb begin
        case (extOp)
            extZero:  imm32 = {16'h0000, imm16};
            extUpper: imm32 = {imm16, 16'h0000};
            default:  imm32 = {{16{imm16[15]}}, imm16};
        endcase
    end

    // a bubble must not write, touch memory or redirect fetch
    assign regWr         = idValid & rawRegWr;
    assign readMem       = idValid & rawReadMem;
    assign writeMem      = idValid & rawWriteMem;
    assign isBranch      = idValid & rawBranch;
    assign isImmJump     = idValid & rawImmJump;
    assign reservedInstr = idValid & rawReserved;

endmodule

// ==== verilog/loadUseHazard.sv ====
// load-use stall detection against loads in EXE and MEM
`timescale 1ns/1ps

module loadUseHazard (
    input  logic       idValid,
    input  logic       rsRead,
    input  logic       rtRead,
    input  logic [4:0] rs,
    input  logic [4:0] rt,
    input  logic [4:0] exeRt,
    input  logic       exeReadMem,
    input  logic [4:0] memRt,
    input  logic       memReadMem,
    output logic       dhStall
);
    logic rsHit;
    logic rtHit;

    // true when idx is the target of a pending load
    function automatic logic loadPending(input logic [4:0] idx);
        if (idx == 5'd0) begin
            return 1'b0;
        end
        return (exeReadMem && (idx == exeRt)) || (memReadMem && (idx == memRt));
    endfunction

    assign rsHit = rsRead && loadPending(rs);
    assign rtHit = rtRead && loadPending(rt);

    // only fields the instruction really reads count
    assign dhStall = idValid && (rsHit || rtHit);

endmodule

// ==== verilog/idStage.sv ====
// decode stage top with IF/ID register, register file, decoder and load-use checker
`timescale 1ns/1ps

module idStage #(
    parameter logic [31:0] resetPc = 32'h0000_0000
) (
    input  logic         clk,
    input  logic         arstN,
    input  logic         idWr,
    input  logic         idFlush,
    input  logic         ifValid,
    input  logic [31:0]  ifInstr,
    input  logic [31:0]  ifPc,
    input  logic         wbWrEn,
    input  logic [4:0]   wbDst,
    input  logic [31:0]  wbResult,
    input  logic [4:0]   exeRt,
    input  logic         exeReadMem,
    input  logic [4:0]   memRt,
    input  logic         memReadMem,
    output logic         idValid,
    output logic [31:0]  idPc,
    output logic [4:0]   idRs,
    output logic [4:0]   idRt,
    output logic [4:0]   idDst,
    output logic [31:0]  idBusA,
    output logic [31:0]  idBusB,
    output logic [31:0]  idImm32,
    output logic [31:0]  idJumpTarget,
    output idPkg::aluOpT idAluOp,
    output logic         idAluSrcImm,
    output logic         idRegWr,
    output logic         idReadMem,
    output logic         idWriteMem,
    output logic         idIsBranch,
    output logic         idIsImmJump,
    output logic         idReservedInstr,
    output logic         dhStall
);
    import idPkg::*;

    instrWordT idInstr;
    logic      rsRead;
    logic      rtRead;

    ifIdReg #(
        .resetPc (resetPc)
    ) u_ifIdReg (
        .clk     (clk),
        .arstN   (arstN),
        .idWr    (idWr),
        .idFlush (idFlush),
        .ifValid (ifValid),
        .ifInstr (ifInstr),
        .ifPc    (ifPc),
        .idValid (idValid),
        .idInstr (idInstr),
        .idPc    (idPc)
    );

    // writeback bypass is inside the register file
    regFile u_regFile (
        .clk      (clk),
        .arstN    (arstN),
        .wbWrEn   (wbWrEn),
        .wbDst    (wbDst),
        .wbResult (wbResult),
        .rs       (idRs),
        .rt       (idRt),
        .busA     (idBusA),
        .busB     (idBusB)
    );

    instrDecoder u_instrDecoder (
        .idInstr       (idInstr),
        .idValid       (idValid),
        .idPc          (idPc),
        .rs            (idRs),
        .rt            (idRt),
        .dst           (idDst),
        .imm32         (idImm32),
        .jumpTarget    (idJumpTarget),
        .aluOp         (idAluOp),
        .aluSrcImm     (idAluSrcImm),
        .regWr         (idRegWr),
        .readMem       (idReadMem),
        .writeMem      (idWriteMem),
        .isBranch      (idIsBranch),
        .isImmJump     (idIsImmJump),
        .rsRead        (rsRead),
        .rtRead        (rtRead),
        .reservedInstr (idReservedInstr)
    );

    // stall goes out and the controller drops idWr
    loadUseHazard u_loadUseHazard (
        .idValid    (idValid),
        .rsRead     (rsRead),
        .rtRead     (rtRead),
        .rs         (idRs),
        .rt         (idRt),
        .exeRt      (exeRt),
        .exeReadMem (exeReadMem),
        .memRt      (memRt),
        .memReadMem (memReadMem),
        .dhStall    (dhStall)
    );

endmodule

// ==== tb/idStage_assert.sv ====
// concurrent checks on the decode stage, bound into idStage
`timescale 1ns/1ps

module idStageAssert (
    input logic        clk,
    input logic        arstN,
    input logic        idFlush,
    input logic        idValid,
    input logic        dhStall,
    input logic [4:0]  idRs,
    input logic [31:0] idBusA
);

    // a bubble never stalls the pipeline
    assert property (@(posedge clk) disable iff (!arstN) idValid || !dhStall)
        else $error("dhStall high while idValid is low");

    // flush leaves a bubble in IF/ID
    assert property (@(posedge clk) disable iff (!arstN) idFlush |=> !idValid)
        else $error("idValid still high after a flush cycle");

    // register 0 reads zero, bypass included
    assert property (@(posedge clk) disable iff (!arstN) (idRs == 5'd0) |-> (idBusA == '0))
        else $error("idBusA nonzero while idRs is register 0");

endmodule

bind idStage idStageAssert i_idStageAssert (
    .clk     (clk),
    .arstN   (arstN),
    .idFlush (idFlush),
    .idValid (idValid),
    .dhStall (dhStall),
    .idRs    (idRs),
    .idBusA  (idBusA)
);

// ==== tb/idStageTb.sv ====
// idStage testbench with clock, reset, directed tests, register model, timeout and summary
`timescale 1ns/1ps

module idStageTb;
    import idPkg::*;

    localparam logic [31:0] resetPc = 32'hbfc00000;
    // limit sits well above the combined length of all tests
    localparam int maxCycles = 2000;

    logic clk = 1'b0;
    logic arstN, idWr, idFlush, ifValid, wbWrEn, exeReadMem, memReadMem;
    logic [31:0] ifInstr, ifPc, wbResult;
    logic [4:0] wbDst, exeRt, memRt;
    logic idValid, idAluSrcImm, idRegWr, idReadMem, idWriteMem, idIsBranch;
    logic idIsImmJump, idReservedInstr, dhStall;
    logic [31:0] idPc, idBusA, idBusB, idImm32, idJumpTarget;
    logic [4:0] idRs, idRt, idDst;
    aluOpT idAluOp;

    logic [31:0] refRegs [32];
    integer seed = 32'h7c58;
    int cycles = 0;
    int testErrs = 0;
    int passCount = 0;
    int failCount = 0;

    idStage #(.resetPc(resetPc)) i_idStage (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        if (cycles == maxCycles) begin
            $display("timeout: tests did not finish within %0d cycles", maxCycles);
            $display("TEST FAIL");
            $finish;
        end else begin
            cycles++;
        end
    end

    function automatic logic [31:0] rInstr(input logic [5:0] funct,
                                           input logic [4:0] rs, rt, rd);
        return {opSpecial, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] iInstr(input logic [5:0] op, input logic [4:0] rs, rt,
                                           input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jInstr(input logic [5:0] op, input logic [25:0] index);
        return {op, index};
    endfunction

    // zero for ANDI and ORI, upper for LUI, sign otherwise
    function automatic logic [31:0] immExpect(input logic [31:0] instr);
        if (instr[31:26] == opAndi || instr[31:26] == opOri) begin
            return {16'h0000, instr[15:0]};
        end
        if (instr[31:26] == opLui) begin
            return {instr[15:0], 16'h0000};
        end
        return {{16{instr[15]}}, instr[15:0]};
    endfunction

    function automatic logic [4:0] randReg();
        return 5'(({$random(seed)} % 31) + 1);
    endfunction

    task automatic checkVal(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Error %s: expected %h, actual %h", name, exp, act);
            testErrs++;
        end
    endtask

    task automatic endTest(input string name);
        if (testErrs == 0) begin
            passCount++;
            $display("test %s passed", name);
        end else begin
            failCount++;
            $display("test %s failed with %0d errors", name, testErrs);
        end
        testErrs = 0;
    endtask

    task automatic writeReg(input logic [4:0] idx, input logic [31:0] val);
        @(negedge clk);
        wbWrEn   = 1'b1;
        wbDst    = idx;
        wbResult = val;
        @(negedge clk);
        wbWrEn = 1'b0;
        if (idx != 5'd0) begin
            refRegs[idx] = val;
        end
    endtask

    // one capture edge and then IF/ID holds
    task automatic fetch(input logic [31:0] instr, input logic [31:0] pc, input logic valid);
        @(negedge clk);
        ifInstr = instr;
        ifPc    = pc;
        ifValid = valid;
        idWr    = 1'b1;
        @(negedge clk);
        idWr = 1'b0;
    endtask

    task automatic resetValues();
        checkVal("idValid", 0, 32'(idValid));
        checkVal("dhStall", 0, 32'(dhStall));
        checkVal("idRegWr", 0, 32'(idRegWr));
        checkVal("idReadMem", 0, 32'(idReadMem));
        checkVal("idWriteMem", 0, 32'(idWriteMem));
        checkVal("idIsImmJump", 0, 32'(idIsImmJump));
        checkVal("idPc", resetPc, idPc);
        endTest("reset");
    endtask

    task automatic regWriteBypass();
        logic [4:0] ra;
        logic [4:0] rb;
        logic [31:0] v;
        for (int k = 0; k < 8; k++) begin
            writeReg(randReg(), $random(seed));
        end
        ra = randReg();
        rb = randReg();
        writeReg(ra, $random(seed));
        writeReg(rb, $random(seed));
        fetch(rInstr(fnAddu, ra, rb, 5'd9), 32'hbfc00010, 1'b1);
        checkVal("idBusA", refRegs[ra], idBusA);
        checkVal("idBusB", refRegs[rb], idBusB);
        v = $random(seed);
        @(negedge clk);
        wbWrEn   = 1'b1;
        wbDst    = ra;
        wbResult = v;
        #1;
        checkVal("idBusA", v, idBusA);
        checkVal("idBusB", (rb == ra) ? v : refRegs[rb], idBusB);
        @(negedge clk);
        wbWrEn      = 1'b0;
        refRegs[ra] = v;
        #1;
        checkVal("idBusA", refRegs[ra], idBusA);
        writeReg(5'd0, 32'hdeadbeef);
        fetch(rInstr(fnAddu, 5'd0, 5'd0, 5'd9), 32'hbfc00014, 1'b1);
        checkVal("idBusA", 0, idBusA);
        checkVal("idBusB", 0, idBusB);
        @(negedge clk);
        wbWrEn   = 1'b1;
        wbDst    = 5'd0;
        wbResult = 32'h5a5a_a5a5;
        #1;
        checkVal("idBusA", 0, idBusA);
        checkVal("idBusB", 0, idBusB);
        @(negedge clk);
        wbWrEn = 1'b0;
        endTest("regfile and bypass");
    endtask

    task automatic expectDecode(input logic [31:0] instr, input logic [31:0] pc,
                                input logic chkAlu, input aluOpT expOp, input logic expImmSrc,
                                input logic expRegWr, input logic [4:0] expDst,
                                input logic expRead, input logic expWrite, input logic expBranch,
                                input logic expJump, input logic expRsv);
        fetch(instr, pc, 1'b1);
        checkVal("idRs", 32'(instr[25:21]), 32'(idRs));
        checkVal("idRt", 32'(instr[20:16]), 32'(idRt));
        if (chkAlu) begin
            checkVal("idAluOp", 32'(expOp), 32'(idAluOp));
        end
        checkVal("idAluSrcImm", 32'(expImmSrc), 32'(idAluSrcImm));
        checkVal("idRegWr", 32'(expRegWr), 32'(idRegWr));
        if (expRegWr) begin
            checkVal("idDst", 32'(expDst), 32'(idDst));
        end
        checkVal("idReadMem", 32'(expRead), 32'(idReadMem));
        checkVal("idWriteMem", 32'(expWrite), 32'(idWriteMem));
        checkVal("idIsBranch", 32'(expBranch), 32'(idIsBranch));
        checkVal("idIsImmJump", 32'(expJump), 32'(idIsImmJump));
        checkVal("idReservedInstr", 32'(expRsv), 32'(idReservedInstr));
        checkVal("idImm32", immExpect(instr), idImm32);
        if (expJump) begin
            checkVal("idJumpTarget", {pc[31:28], instr[25:0], 2'b00}, idJumpTarget);
        end
    endtask

    task automatic decodeSubset();
        logic [4:0] ra;
        logic [4:0] rb;
        logic [4:0] rd;
        logic [15:0] imm;
        logic [31:0] pc;
        ra  = randReg();
        rb  = randReg();
        rd  = randReg();
        imm = 16'($random(seed)) | 16'h8000;
        pc  = $random(seed) & 32'hffff_fffc;
        expectDecode(rInstr(fnAddu, ra, rb, rd), pc, 1, aluAdd, 0, 1, rd, 0, 0, 0, 0, 0);
        expectDecode(rInstr(fnSubu, ra, rb, rd), pc, 1, aluSub, 0, 1, rd, 0, 0, 0, 0, 0);
        expectDecode(rInstr(fnAnd, ra, rb, rd), pc, 1, aluAnd, 0, 1, rd, 0, 0, 0, 0, 0);
        expectDecode(rInstr(fnOr, ra, rb, rd), pc, 1, aluOr, 0, 1, rd, 0, 0, 0, 0, 0);
        expectDecode(rInstr(fnSlt, ra, rb, rd), pc, 1, aluSlt, 0, 1, rd, 0, 0, 0, 0, 0);
        expectDecode(iInstr(opAddiu, ra, rb, imm), pc, 1, aluAdd, 1, 1, rb, 0, 0, 0, 0, 0);
        expectDecode(iInstr(opAndi, ra, rb, imm), pc, 1, aluAnd, 1, 1, rb, 0, 0, 0, 0, 0);
        expectDecode(iInstr(opOri, ra, rb, imm), pc, 1, aluOr, 1, 1, rb, 0, 0, 0, 0, 0);
        expectDecode(iInstr(opSlti, ra, rb, imm), pc, 1, aluSlt, 1, 1, rb, 0, 0, 0, 0, 0);
        expectDecode(iInstr(opLui, 5'd0, rb, imm), pc, 1, aluLui, 1, 1, rb, 0, 0, 0, 0, 0);
        expectDecode(iInstr(opLw, ra, rb, imm), pc, 1, aluAdd, 1, 1, rb, 1, 0, 0, 0, 0);
        expectDecode(iInstr(opSw, ra, rb, imm), pc, 1, aluAdd, 1, 0, 0, 0, 1, 0, 0, 0);
        expectDecode(iInstr(opBeq, ra, rb, imm), pc, 1, aluSub, 0, 0, 0, 0, 0, 1, 0, 0);
        expectDecode(jInstr(opJ, 26'($random(seed))), pc, 0, aluAdd, 0, 0, 0, 0, 0, 0, 1, 0);
        expectDecode(jInstr(opJal, 26'($random(seed))), pc, 0, aluAdd, 0, 1, 5'd31,
                     0, 0, 0, 1, 0);
        // undefined opcode and an unsupported funct
        expectDecode(iInstr(6'h3f, ra, rb, imm), pc, 0, aluAdd, 0, 0, 0, 0, 0, 0, 0, 1);
        expectDecode(rInstr(6'h00, ra, rb, rd), pc, 0, aluAdd, 0, 0, 0, 0, 0, 0, 0, 1);
        endTest("decode");
    endtask

    task automatic holdAndFlush();
        logic [31:0] pc;
        pc = 32'hbfc00100;
        fetch(iInstr(opOri, 5'd3, 5'd4, 16'h1234), pc, 1'b1);
        repeat (3) begin
            @(negedge clk);
            ifInstr = $random(seed);
            ifPc    = $random(seed);
            ifValid = 1'b1;
            @(posedge clk);
            #1;
            checkVal("idValid", 1, 32'(idValid));
            checkVal("idPc", pc, idPc);
            checkVal("idImm32", 32'h0000_1234, idImm32);
            checkVal("idDst", 32'd4, 32'(idDst));
            checkVal("idRegWr", 1, 32'(idRegWr));
        end
        // flush beats a concurrent write
        @(negedge clk);
        idFlush = 1'b1;
        idWr    = 1'b1;
        @(negedge clk);
        idFlush = 1'b0;
        idWr    = 1'b0;
        checkVal("idValid", 0, 32'(idValid));
        checkVal("idPc", pc, idPc);
        checkVal("idRegWr", 0, 32'(idRegWr));
        endTest("hold and flush");
    endtask

    task automatic stallCase(input logic [4:0] eRt, input logic eLd, input logic [4:0] mRt,
                             input logic mLd, input logic exp);
        @(negedge clk);
        exeRt      = eRt;
        exeReadMem = eLd;
        memRt      = mRt;
        memReadMem = mLd;
        #1;
        checkVal("dhStall", 32'(exp), 32'(dhStall));
    endtask

    task automatic loadUseStall();
        fetch(rInstr(fnAddu, 5'd5, 5'd6, 5'd7), 32'hbfc00200, 1'b1);
        stallCase(5'd5, 1, 5'd0, 0, 1);
        stallCase(5'd6, 1, 5'd0, 0, 1);
        stallCase(5'd0, 0, 5'd5, 1, 1);
        stallCase(5'd0, 0, 5'd6, 1, 1);
        stallCase(5'd5, 0, 5'd6, 0, 0);
        stallCase(5'd9, 1, 5'd10, 1, 0);
        fetch(rInstr(fnAddu, 5'd0, 5'd6, 5'd7), 32'hbfc00204, 1'b1);
        stallCase(5'd0, 1, 5'd0, 1, 0);
        // rt of ADDIU is a destination rather than a source
        fetch(iInstr(opAddiu, 5'd7, 5'd8, 16'h0004), 32'hbfc00208, 1'b1);
        stallCase(5'd8, 1, 5'd8, 1, 0);
        stallCase(5'd7, 1, 5'd0, 0, 1);
        fetch(rInstr(fnAddu, 5'd5, 5'd6, 5'd7), 32'hbfc0020c, 1'b0);
        stallCase(5'd5, 1, 5'd6, 1, 0);
        stallCase(5'd0, 0, 5'd0, 0, 0);
        endTest("load-use stall");
    endtask

    initial begin
        arstN      = 1'b0;
        idWr       = 1'b0;
        idFlush    = 1'b0;
        ifValid    = 1'b0;
        ifInstr    = '0;
        ifPc       = '0;
        wbWrEn     = 1'b0;
        wbDst      = '0;
        wbResult   = '0;
        exeRt      = '0;
        exeReadMem = 1'b0;
        memRt      = '0;
        memReadMem = 1'b0;
        for (int i = 0; i < 32; i++) begin
            refRegs[i] = '0;
        end
        repeat (8) @(negedge clk);
        arstN = 1'b1;
        resetValues();
        regWriteBypass();
        decodeSubset();
        holdAndFlush();
        loadUseStall();
        $display("summary: %0d tests passed, %0d tests failed", passCount, failCount);
        if (failCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== idStage.f ====
verilog/idPkg.sv
verilog/ifIdReg.sv
verilog/regFile.sv
verilog/instrDecoder.sv
verilog/loadUseHazard.sv
verilog/idStage.sv
tb/idStage_assert.sv
tb/idStageTb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = idStageTb
FILELIST = idStage.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "TEST PASS" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
